//--- frame_timer.sv
`timescale 1ns/10ps

module frame_timer (
	input  logic                    clk,
	input  logic                    resetN,
	input  logic                    step_load,
	input  sound_pkg::step_frames_t step_len,
	output logic                    frame_tick,
	output logic                    step_done
);

	logic [sound_pkg::FRAME_CNT_W-1:0] frame_cnt;      // Phase within the frame
	sound_pkg::step_frames_t           step_cnt;       // Frames left in the current step

	assign frame_tick = (frame_cnt == sound_pkg::FRAME_CNT_W'(sound_pkg::FRAME_CLKS - 1));
	assign step_done  = (step_cnt == '0);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frame_cnt <= '0;
		end
		else if (frame_tick) begin
			frame_cnt <= '0;
		end
		else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			step_cnt <= '0;
		end
		else if (step_load) begin
			step_cnt <= step_len;                          // Load wins over a same-cycle tick
		end
		else if (frame_tick && !step_done) begin
			step_cnt <= step_cnt - 1'b1;
		end
	end

	// Counter only moves down between loads
	a_no_wrap: assert property (
		@(posedge clk) disable iff (!resetN)
		!step_load |=> (step_cnt <= $past(step_cnt))
	) else $error("step counter wrapped below zero");

endmodule

//--- list.f
sound_pkg.sv
sound_event_latch.sv
frame_timer.sv
sound_sequencer.sv
tone_generator.sv
sound_top.sv
tb_clock_gen.sv
tb_sound_top.sv

//--- sound_event_latch.sv
`timescale 1ns/10ps

module sound_event_latch (
	input  logic                     clk,
	input  logic                     resetN,
	input  sound_pkg::sound_events_t events,
	input  logic                     accept,
	output sound_pkg::sound_events_t pending
);

	sound_pkg::sound_events_t kept;                    // Pending bits surviving this cycle

	// ********************************************************
	// Pending request register
	// ********************************************************

	always_comb begin
		if (accept)
			kept = '0;                                     // Sequencer took its pick
		else
			kept = pending;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pending <= '0;
		end
		else begin
			pending <= kept | events;                      // New pulses always merge in
		end
	end

	// ********************************************************
	// Checks
	// ********************************************************

	// The sequencer may only take a request that is actually waiting
	a_accept_needs_pending: assert property (
		@(posedge clk) disable iff (!resetN)
		accept |-> (pending != '0)
	) else $error("accept with nothing pending");

endmodule

//--- sound_pkg.sv
package sound_pkg;

	// ********************************************************
	// Frame timing
	// ********************************************************

	localparam int FRAME_CLKS  = 64;                       // Clock cycles per video frame
	localparam int FRAME_CNT_W = 7;                        // Frame phase counter width

	// ********************************************************
	// Types
	// ********************************************************

	typedef struct packed {
		logic player_hit;
		logic pickup;
		logic bird_hit;
		logic level_up;
		logic shot;
	} sound_events_t;

	typedef logic [9:0] tone_div_t;                        // Half-period in clocks, 0 is silence
	typedef logic [3:0] step_frames_t;                     // Step length in frames

	typedef struct packed {
		tone_div_t    div;
		step_frames_t frames;
	} tone_step_t;

	typedef enum logic [2:0] {
		fx_none,
		fx_hit,
		fx_pickup,
		fx_bird,
		fx_level,
		fx_shot
	} effect_e;

	typedef enum logic [1:0] {
		st_idle,
		st_step_1,
		st_step_2,
		st_step_3
	} seq_state_e;

	// ********************************************************
	// Effect melodies, three steps each, indexed by effect_e
	// ********************************************************

	localparam tone_step_t EFFECT_STEPS [0:5][0:2] = '{
		'{'{10'h000, 4'd0}, '{10'h000, 4'd0}, '{10'h000, 4'd0}},  // fx_none
		'{'{10'h250, 4'd4}, '{10'h2EA, 4'd4}, '{10'h000, 4'd4}},  // fx_hit
		'{'{10'h1F2, 4'd8}, '{10'h250, 4'd8}, '{10'h1BB, 4'd8}},  // fx_pickup
		'{'{10'h20F, 4'd4}, '{10'h1D6, 4'd4}, '{10'h18B, 4'd4}},  // fx_bird
		'{'{10'h000, 4'd4}, '{10'h000, 4'd4}, '{10'h000, 4'd4}},  // fx_level, quiet
		'{'{10'h1F2, 4'd4}, '{10'h250, 4'd2}, '{10'h2EA, 4'd1}}   // fx_shot
	};

endpackage

//--- sound_sequencer.sv
`timescale 1ns/10ps

module sound_sequencer (
	input  logic                     clk,
	input  logic                     resetN,
	input  sound_pkg::sound_events_t pending,
	input  logic                     step_done,
	output logic                     accept,
	output logic                     step_load,
	output sound_pkg::step_frames_t  step_len,
	output sound_pkg::tone_div_t     tone_div,
	output logic                     sound_en
);

	sound_pkg::seq_state_e state;
	sound_pkg::seq_state_e next_state;
	sound_pkg::effect_e    effect;
	sound_pkg::effect_e    next_effect;
	sound_pkg::effect_e    pick_fx;                    // Highest-priority pending event
	sound_pkg::tone_step_t cur_step;
	sound_pkg::tone_step_t next_step;
	logic                  start;
	logic                  advance;

	// Table column of a state where idle shares column 0
	function automatic logic [1:0] step_idx(input sound_pkg::seq_state_e s);
		case (s)
			sound_pkg::st_step_2: return 2'd1;
			sound_pkg::st_step_3: return 2'd2;
			default:              return 2'd0;
		endcase
	endfunction

	// ********************************************************
	// Effect selection and next state
	// ********************************************************

	always_comb begin
		if (pending.player_hit)
			pick_fx = sound_pkg::fx_hit;
		else if (pending.pickup)
			pick_fx = sound_pkg::fx_pickup;
		else if (pending.bird_hit)
			pick_fx = sound_pkg::fx_bird;
		else if (pending.level_up)
			pick_fx = sound_pkg::fx_level;
		else if (pending.shot)
			pick_fx = sound_pkg::fx_shot;
		else
			pick_fx = sound_pkg::fx_none;
	end

	assign start   = step_done && (pending != '0);    // Also preempts a playing effect
	assign advance = step_done && !start && (state != sound_pkg::st_idle);

	always_comb begin
		next_state  = state;
		next_effect = effect;
		if (start) begin
			next_state  = sound_pkg::st_step_1;
			next_effect = pick_fx;
		end
		else if (advance) begin
			case (state)
				sound_pkg::st_step_1: next_state = sound_pkg::st_step_2;
				sound_pkg::st_step_2: next_state = sound_pkg::st_step_3;
				default: begin
					next_state  = sound_pkg::st_idle;
					next_effect = sound_pkg::fx_none;
				end
			endcase
		end
	end

	assign next_step = sound_pkg::EFFECT_STEPS[next_effect][step_idx(next_state)];
	assign cur_step  = sound_pkg::EFFECT_STEPS[effect][step_idx(state)];

	assign accept    = start;
	assign step_load = start || (advance && state != sound_pkg::st_step_3);
	assign step_len  = next_step.frames;

	// ********************************************************
	// State and output registers
	// ********************************************************

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state    <= sound_pkg::st_idle;
			effect   <= sound_pkg::fx_none;
			tone_div <= '0;
			sound_en <= 1'b0;
		end
		else begin
			state    <= next_state;
			effect   <= next_effect;
			tone_div <= (state == sound_pkg::st_idle) ? '0 : cur_step.div;
			sound_en <= (state != sound_pkg::st_idle);  // One cycle behind the state
		end
	end

	// Enable is high exactly while an effect is held
	a_en_tracks_state: assert property (
		@(posedge clk) disable iff (!resetN)
		##1 (sound_en == ($past(effect) != sound_pkg::fx_none))
	) else $error("sound_en out of step with state");

	// A load either moves the FSM or restarts an effect on accept
	a_load_with_change: assert property (
		@(posedge clk) disable iff (!resetN)
		step_load |=> ((state != $past(state)) || $past(accept))
	) else $error("step_load without state change");

endmodule

//--- sound_top.sv
`timescale 1ns/10ps

module sound_top (
	input  logic                     clk,
	input  logic                     resetN,
	input  sound_pkg::sound_events_t events,
	output sound_pkg::tone_div_t     tone_div,
	output logic                     sound_en,
	output logic                     audio
);

	sound_pkg::sound_events_t pending;
	sound_pkg::step_frames_t  step_len;
	logic                     accept;
	logic                     step_load;
	logic                     step_done;
	logic                     frame_tick;

	sound_event_latch u_latch (
		.clk(clk), .resetN(resetN),
		.events(events), .accept(accept), .pending(pending)
	);

	frame_timer u_timer (
		.clk(clk), .resetN(resetN),
		.step_load(step_load), .step_len(step_len),
		.frame_tick(frame_tick), .step_done(step_done)
	);

	sound_sequencer u_seq (
		.clk(clk), .resetN(resetN),
		.pending(pending), .step_done(step_done),
		.accept(accept), .step_load(step_load), .step_len(step_len),
		.tone_div(tone_div), .sound_en(sound_en)
	);

	tone_generator u_tone (
		.clk(clk), .resetN(resetN),
		.tone_div(tone_div), .sound_en(sound_en), .audio(audio)
	);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic resetN
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                             // 8 ns period
	end

	initial begin
		resetN = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;                                     // Release away from the sampling edge
	end

endmodule

//--- tb_sound_top.sv
`timescale 1ns/10ps

module tb_sound_top;

	localparam int N_EVENTS = 240;
	localparam int LIMIT    = N_EVENTS * 24 * sound_pkg::FRAME_CLKS + 8000;

	logic                     clk;
	logic                     resetN;
	sound_pkg::sound_events_t events;
	sound_pkg::tone_div_t     tone_div;
	logic                     sound_en;
	logic                     audio;

	integer seed;
	int     cycles = 0;
	int     n_started;
	int     n_preempt;

	// ********************************************************
	// Reference model and audio monitor state
	// ********************************************************

	sound_pkg::sound_events_t cur_ev;                  // Events held over the last rising edge
	sound_pkg::sound_events_t m_pending;
	sound_pkg::effect_e       m_fx;
	int                       m_idx;                   // Step 0..2 of the playing effect
	logic                     m_busy;
	int                       m_frame;
	int                       m_step;
	int                       m_age;                   // Cycles since the last step load
	int                       m_len;
	sound_pkg::tone_div_t     m_div;
	logic                     m_en;
	logic                     m_started;
	sound_pkg::sound_events_t m_start_ev;
	logic                     prev_audio;
	logic                     prev_active;
	sound_pkg::tone_div_t     prev_div;
	logic                     run_ok;                  // Half-period measurement is valid
	int                       half_cnt;

	tb_clock_gen u_clk (.clk(clk), .resetN(resetN));

	sound_top u_dut (
		.clk(clk), .resetN(resetN), .events(events),
		.tone_div(tone_div), .sound_en(sound_en), .audio(audio)
	);

	// Keeps only the highest-priority event
	function automatic sound_pkg::sound_events_t highest_event(sound_pkg::sound_events_t p);
		logic [4:0] v;
		v = p;
		casez (v)
			5'b1????: return 5'b10000;
			5'b01???: return 5'b01000;
			5'b001??: return 5'b00100;
			5'b0001?: return 5'b00010;
			default:  return v;
		endcase
	endfunction

	function automatic sound_pkg::effect_e event_fx(sound_pkg::sound_events_t e);
		logic [4:0] v;
		v = e;
		case (v)
			5'b10000: return sound_pkg::fx_hit;
			5'b01000: return sound_pkg::fx_pickup;
			5'b00100: return sound_pkg::fx_bird;
			5'b00010: return sound_pkg::fx_level;
			5'b00001: return sound_pkg::fx_shot;
			default:  return sound_pkg::fx_none;
		endcase
	endfunction

	function automatic sound_pkg::sound_events_t fx_events(sound_pkg::effect_e fx);
		case (fx)
			sound_pkg::fx_hit:    return 5'b10000;
			sound_pkg::fx_pickup: return 5'b01000;
			sound_pkg::fx_bird:   return 5'b00100;
			sound_pkg::fx_level:  return 5'b00010;
			sound_pkg::fx_shot:   return 5'b00001;
			default:              return 5'b00000;
		endcase
	endfunction

	function automatic string event_name(sound_pkg::sound_events_t e);
		logic [4:0] v;
		v = e;
		case (v)
			5'b10000: return "player_hit";
			5'b01000: return "pickup";
			5'b00100: return "bird_hit";
			5'b00010: return "level_up";
			5'b00001: return "shot";
			5'b00000: return "none";
			default:  return "several";
		endcase
	endfunction

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	// ********************************************************
	// Compare tasks
	// ********************************************************

	task automatic check_div(input string name, input sound_pkg::tone_div_t exp,
		input sound_pkg::tone_div_t got);
		if (exp !== got) begin
			$display("ERR %0t %s exp=%0h got=%0h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_en(input string name, input logic exp, input logic got);
		if (exp !== got) begin
			$display("ERR %0t %s exp=%b got=%b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_events(input string name, input sound_pkg::sound_events_t exp,
		input sound_pkg::sound_events_t got);
		if (exp !== got) begin
			$display("ERR %0t %s exp=%b (%s) got=%b (%s)", $time, name,
				exp, event_name(exp), got, event_name(got));
			abort_run();
		end
	endtask

	// One rising edge of the reference model
	task automatic model_step();
		logic                     tick;
		logic                     done;
		logic                     load;
		sound_pkg::sound_events_t pick;
		tick = (m_frame == sound_pkg::FRAME_CLKS - 1);
		done = (m_step == 0);
		load = 1'b0;
		pick = highest_event(m_pending);
		m_age++;
		m_started = 1'b0;
		m_en  = m_busy;
		m_div = m_busy ? sound_pkg::EFFECT_STEPS[m_fx][m_idx].div : '0;
		if (done && m_busy) begin
			if (m_age < (m_len - 1) * sound_pkg::FRAME_CLKS + 1 ||
				m_age > m_len * sound_pkg::FRAME_CLKS + 1) begin
				$display("Step of %0d frames lasted %0d cycles, outside its window",
					m_len, m_age);
				abort_run();
			end
		end
		if (done && pick != '0) begin
			n_started++;
			n_preempt += m_busy;
			m_fx       = event_fx(pick);
			m_idx      = 0;
			m_busy     = 1'b1;
			load       = 1'b1;
			m_started  = 1'b1;
			m_start_ev = pick;
		end
		else if (done && m_busy) begin
			if (m_idx == 2) begin
				m_busy = 1'b0;                             // Melody over
				m_fx   = sound_pkg::fx_none;
			end
			else begin
				m_idx++;
				load = 1'b1;
			end
		end
		if (load) begin
			m_len  = sound_pkg::EFFECT_STEPS[m_fx][m_idx].frames;
			m_step = m_len;
			m_age  = 0;
		end
		else if (tick && m_step != 0) begin
			m_step--;
		end
		m_frame   = tick ? 0 : m_frame + 1;
		m_pending = ((done && pick != '0) ? '0 : m_pending) | cur_ev;
	endtask

	task automatic audio_watch();
		half_cnt++;
		if (!prev_active)
			check_en("audio", 1'b0, audio);
		if (audio != prev_audio) begin
			if (run_ok)
				check_div("audio half-period", prev_div, sound_pkg::tone_div_t'(half_cnt));
			half_cnt = 0;
		end
		else if (run_ok && half_cnt > int'(prev_div)) begin
			check_div("audio half-period", prev_div, sound_pkg::tone_div_t'(half_cnt));
		end
		if (tone_div != prev_div || !sound_en || tone_div == '0) begin
			run_ok   = sound_en && (tone_div != '0);       // Count restarts one edge later
			half_cnt = -1;
		end
		prev_audio  = audio;
		prev_div    = tone_div;
		prev_active = sound_en && (tone_div != '0);
	endtask

	task automatic run_cycle(input sound_pkg::sound_events_t ev);
		@(negedge clk);
		model_step();
		check_div("tone_div", m_div, tone_div);
		check_en("sound_en", m_en, sound_en);
		check_events("pending", m_pending, u_dut.pending);
		if (m_started)
			check_events("started event", m_start_ev, fx_events(u_dut.u_seq.effect));
		audio_watch();
		events = ev;
		cur_ev = ev;
	endtask

	task automatic make_event(output sound_pkg::sound_events_t ev);
		logic [31:0] r;
		logic [4:0]  bits;
		r = $random(seed);
		if (r[2:0] == 3'd0) begin
			bits = r[12:8];
			if ($countones(bits) < 2)
				bits = bits | 5'b01001;                    // Force a collision
		end
		else begin
			bits = 5'b00001 << (r[6:4] % 3'd5);
		end
		ev = bits;
	endtask

	// ********************************************************
	// Stimulus and timeout
	// ********************************************************

	initial begin
		sound_pkg::sound_events_t ev;
		logic [31:0]              r;
		int                       gap;
		int                       len;
		seed        = 32'ha7e5_fe62;
		events      = '0;
		cur_ev      = '0;
		m_pending   = '0;
		m_fx        = sound_pkg::fx_none;
		m_idx       = 0;
		m_busy      = 1'b0;
		m_frame     = 0;
		m_step      = 0;
		m_age       = 0;
		m_len       = 0;
		m_div       = '0;
		m_en        = 1'b0;
		m_started   = 1'b0;
		m_start_ev  = '0;
		prev_audio  = 1'b0;
		prev_active = 1'b0;
		prev_div    = '0;
		run_ok      = 1'b0;
		half_cnt    = 0;
		n_started   = 0;
		n_preempt   = 0;
		@(posedge resetN);
		repeat (20) run_cycle('0);                         // Quiet after reset
		for (int n = 0; n < N_EVENTS; n++) begin
			make_event(ev);
			r   = $random(seed);
			len = r[3] ? 2 : 1;
			gap = (r[7:0] < 8'd40) ? 1 + int'(r[31:16] % 200) : 200 + int'(r[31:16] % 1300);
			repeat (len) run_cycle(ev);
			repeat (gap) run_cycle('0);
		end
		while (m_busy || m_pending != '0 || m_step != 0)
			run_cycle('0);
		repeat (20) run_cycle('0);
		if (n_started >= N_EVENTS / 2 && n_preempt > 0) begin
			$display("RESULT: PASS");
			$finish;
		end
		else begin
			$display("Random run started %0d effects with %0d preemptions, too few",
				n_started, n_preempt);
			abort_run();
		end
	end

	always @(posedge clk) begin
		if (resetN) begin
			cycles++;
			if (cycles > LIMIT) begin
				$display("Timeout after %0d cycles, the run did not finish", cycles);
				abort_run();
			end
		end
	end

endmodule

//--- tone_generator.sv
`timescale 1ns/10ps

module tone_generator (
	input  logic                 clk,
	input  logic                 resetN,
	input  sound_pkg::tone_div_t tone_div,
	input  logic                 sound_en,
	output logic                 audio
);

	sound_pkg::tone_div_t half_cnt;                    // Cycles into the current half-period
	sound_pkg::tone_div_t last_div;
	logic                 active;
	logic                 wrap;

	assign active = sound_en && (tone_div != '0);
	assign wrap   = (half_cnt == tone_div - 1'b1);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			last_div <= '0;
		end
		else begin
			last_div <= tone_div;
		end
	end

	// ********************************************************
	// Half-period divider
	// ********************************************************

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			half_cnt <= '0;
			audio    <= 1'b0;
		end
		else if (!active) begin
			half_cnt <= '0;                                // Silent, hold low
			audio    <= 1'b0;
		end
		else if (tone_div != last_div) begin
			half_cnt <= '0;                                // New pitch, restart count
		end
		else if (wrap) begin
			half_cnt <= '0;
			audio    <= ~audio;
		end
		else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	a_quiet_when_off: assert property (
		@(posedge clk) disable iff (!resetN)
		!sound_en |=> !audio
	) else $error("audio high with sound_en low");

endmodule
